// File: retire_core.f
hdl/retire_pkg.sv
hdl/reorder_buffer.sv
hdl/commit_unit.sv
hdl/arch_regfile.sv
hdl/uncached_port.sv
hdl/retire_core.sv
dv/retire_tb.sv

// File: dv/retire_tb.sv
`timescale 1ns/10ps

module retire_tb
    import retire_pkg::*;
();

    localparam int TOTAL_INSTR = 40 + 2 + 9 + 200 + 12; // dispatches over all tests
    localparam int MAX_CYCLES  = 200 * TOTAL_INSTR + 1000;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       dispatch_valid_i;
    rob_entry_t dispatch_entry_i;
    logic       rob_full_o;
    arch_rid_t  rd_addr_i;
    word_t      rd_data_o;
    logic       flush_o;
    logic       idle_o;

    word_t       model_regs [32];
    word_t       model_mem  [64];
    logic [31:0] lcg_state      = 32'h3e54;
    logic        pending_flush  = 1'b0; // a flushing op is still ahead in the pipe
    int          cycles         = 0;
    int          flush_seen     = 0;
    int          flush_expected = 0;
    int          discarded      = 0;
    int          errors         = 0;
    int          tests_run      = 0;
    int          tests_failed   = 0;

    retire_core u_retire_core (
        .clk(clk), .rst_n(rst_n),
        .dispatch_valid_i(dispatch_valid_i), .dispatch_entry_i(dispatch_entry_i),
        .rob_full_o(rob_full_o), .rd_addr_i(rd_addr_i), .rd_data_o(rd_data_o),
        .flush_o(flush_o), .idle_o(idle_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles, stopping", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // count flush pulses, younger dispatches are safe again afterwards
    always @(posedge clk) begin
        if (rst_n && flush_o) begin
            flush_seen++;
            pending_flush = 1'b0;
        end
    end

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16]; // upper bits are the better ones
    endfunction

    function automatic rob_entry_t make_entry(input commit_op_e op, input arch_rid_t rd,
                                              input logic [5:0] widx);
        rob_entry_t e;
        e.op    = op;
        e.wreg  = rd;
        e.wdata = {rand16(), rand16()};
        e.addr  = {24'h0, widx, 2'b00};
        return e;
    endfunction

    function automatic commit_op_e pick_op();
        logic [2:0] r;
        r = 3'(rand16() % 8);
        if (r < 3'd4) return op_alu;
        else if (r == 3'd4) return op_uload;
        else if (r < 3'd7) return op_ustore;
        else return op_serialize;
    endfunction

    // architectural effect of one instruction in program order
    function automatic void apply_model(input rob_entry_t e);
        case (e.op)
            op_alu: begin
                if (e.wreg != 5'd0) model_regs[e.wreg] = e.wdata;
            end
            op_uload: begin
                if (e.wreg != 5'd0) model_regs[e.wreg] = model_mem[e.addr[7:2]];
            end
            op_ustore: model_mem[e.addr[7:2]] = e.wdata;
            default: ; // serialize only flushes
        endcase
    endfunction

    // called at a falling edge, returns at a falling edge
    task automatic dispatch(input rob_entry_t e);
        while (rob_full_o || flush_o) begin
            @(negedge clk);
        end
        dispatch_valid_i = 1'b1;
        dispatch_entry_i = e;
        if (pending_flush) begin
            discarded++; // will be wiped by the pending flush
        end else begin
            apply_model(e);
            if (e.op == op_uload || e.op == op_serialize) begin
                pending_flush = 1'b1;
                flush_expected++;
            end
        end
        @(negedge clk);
        dispatch_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (idle_o !== 1'b1) begin
            @(negedge clk);
        end
        // an empty buffer can never report full
        if (rob_full_o !== 1'b0) begin
            $display("[FAIL] t=%0t rob_full_o got %b expected 0", $time, rob_full_o);
            errors++;
        end
    endtask

    task automatic check_regs();
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            rd_addr_i = arch_rid_t'(r);
            #1;
            if (rd_data_o !== model_regs[r]) begin
                $display("[FAIL] t=%0t rd_data_o[x%0d] got %h expected %h",
                         $time, r, rd_data_o, model_regs[r]);
                errors++;
            end
        end
        @(negedge clk);
    endtask

    task automatic check_flushes(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] t=%0t flush_o pulses in %s got %0d expected %0d",
                     $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
        end
    endtask

    task automatic apply_reset();
        rst_n            = 1'b0;
        dispatch_valid_i = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        for (int w = 0; w < 64; w++) model_mem[w] = '0;
        pending_flush = 1'b0;
    endtask

    initial begin
        rob_entry_t e;
        int         err0;
        int         flush0;
        int         fexp0;
        int         disc0;
        rst_n            = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_entry_i = '0;
        rd_addr_i        = '0;
        apply_reset();

        // dual retire with many repeated destinations, x0 included
        err0 = errors;
        for (int i = 0; i < 40; i++) begin
            dispatch(make_entry(op_alu, arch_rid_t'(rand16() % 8), 6'd0));
        end
        wait_idle();
        check_regs();
        end_test("alu burst", err0);

        err0   = errors;
        flush0 = flush_seen;
        dispatch(make_entry(op_ustore, 5'd3, 6'd9));
        wait_idle();
        check_flushes("uncached store", flush_seen - flush0, 0);
        dispatch(make_entry(op_uload, 5'd7, 6'd9));
        wait_idle();
        check_flushes("uncached load", flush_seen - flush0, 1);
        check_regs();
        end_test("store then load", err0);

        err0   = errors;
        flush0 = flush_seen;
        disc0  = discarded;
        dispatch(make_entry(op_serialize, 5'd0, 6'd0));
        repeat (5) dispatch(make_entry(op_alu, arch_rid_t'(rand16() % 32), 6'd0));
        if (discarded == disc0) begin
            $display("serialize: nothing was dispatched ahead of its flush");
            errors++;
        end
        repeat (3) dispatch(make_entry(op_alu, arch_rid_t'(rand16() % 32), 6'd0));
        wait_idle();
        check_flushes("serialize", flush_seen - flush0, 1);
        check_regs();
        end_test("serialize shadow", err0);

        err0   = errors;
        flush0 = flush_seen;
        fexp0  = flush_expected;
        for (int i = 0; i < 200; i++) begin
            e = make_entry(pick_op(), arch_rid_t'(rand16() % 32), 6'(rand16() % 8));
            dispatch(e);
        end
        wait_idle();
        check_flushes("mixed program", flush_seen - flush0, flush_expected - fexp0);
        check_regs();
        end_test("mixed program", err0);

        // reset lands while loads and alu ops are still in flight
        err0 = errors;
        for (int i = 0; i < 12; i++) begin
            e = make_entry((i % 4 == 1) ? op_uload : op_alu, arch_rid_t'(rand16() % 32),
                           6'(rand16() % 8));
            dispatch(e);
        end
        apply_reset();
        flush0 = flush_seen;
        wait_idle();
        repeat (20) @(negedge clk);
        check_flushes("reset mid-run", flush_seen - flush0, 0);
        check_regs();
        end_test("reset mid-run", err0);

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: hdl/retire_core.sv
`timescale 1ns/10ps

module retire_core
    import retire_pkg::*;
#(
    parameter int ROB_DEPTH   = 16,
    parameter int MEM_LATENCY = 3,
    parameter int MEM_WORDS   = 64
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       dispatch_valid_i,
    input  rob_entry_t dispatch_entry_i,
    output logic       rob_full_o,
    input  arch_rid_t  rd_addr_i,
    output word_t      rd_data_o,
    output logic       flush_o,
    output logic       idle_o
);

    logic [1:0]       head_valid;
    rob_entry_t [1:0] head_entry;
    logic [1:0]       retire;
    logic             rob_empty;
    logic             commit_idle;
    mem_req_t         mem_req;
    mem_resp_t        mem_resp;
    arf_wr_t [1:0]    arf_wr;

    assign idle_o = rob_empty && commit_idle;

    reorder_buffer #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_rob (
        .clk(clk), .rst_n(rst_n),
        .alloc_i(dispatch_valid_i), .alloc_entry_i(dispatch_entry_i),
        .full_o(rob_full_o), .empty_o(rob_empty),
        .head_valid_o(head_valid), .head_entry_o(head_entry),
        .retire_i(retire), .flush_i(flush_o)
    );

    commit_unit u_commit (
        .clk(clk), .rst_n(rst_n),
        .head_valid_i(head_valid), .head_entry_i(head_entry), .retire_o(retire),
        .mem_req_o(mem_req), .mem_resp_i(mem_resp),
        .arf_wr_o(arf_wr), .flush_o(flush_o), .idle_o(commit_idle)
    );

    arch_regfile u_arf (
        .clk(clk), .rst_n(rst_n),
        .wr_i(arf_wr), .rd_addr_i(rd_addr_i), .rd_data_o(rd_data_o)
    );

    uncached_port #(
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_WORDS(MEM_WORDS)
    ) u_umem (
        .clk(clk), .rst_n(rst_n), .req_i(mem_req), .resp_o(mem_resp)
    );

endmodule

// File: hdl/uncached_port.sv
`timescale 1ns/10ps

module uncached_port
    import retire_pkg::*;
#(
    parameter int MEM_LATENCY = 3,
    parameter int MEM_WORDS   = 64
) (
    input  logic      clk,
    input  logic      rst_n,
    input  mem_req_t  req_i,
    output mem_resp_t resp_o
);

    localparam int AW = $clog2(MEM_WORDS);
    localparam int CW = $clog2(MEM_LATENCY + 1);

    word_t          mem_q [MEM_WORDS];
    logic [CW-1:0]  cnt_q;     // cycles left for the outstanding access
    logic [AW-1:0]  rd_idx_q;
    logic [AW-1:0]  req_idx;
    logic           busy;

    assign req_idx = req_i.addr[AW+1:2]; // word addressed
    assign busy    = (cnt_q != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (req_i.valid) begin
            cnt_q <= CW'(MEM_LATENCY);
        end else if (busy) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.valid) begin
            rd_idx_q <= req_idx;
        end
    end

    // store data lands on acceptance
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (req_i.valid && req_i.write) begin
            mem_q[req_idx] <= req_i.wdata;
        end
    end

    // done strobe in the last cycle of the countdown
    assign resp_o.valid = (cnt_q == CW'(1));
    assign resp_o.rdata = mem_q[rd_idx_q];

    a_one_outstanding: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_i.valid |-> !busy
    ) else $error("request while an access is outstanding");

endmodule

// File: hdl/arch_regfile.sv
`timescale 1ns/10ps

module arch_regfile
    import retire_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  arf_wr_t [1:0] wr_i,
    input  arch_rid_t     rd_addr_i,
    output word_t         rd_data_o
);

    word_t regs_q [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 1; r < 32; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (wr_i[i].en && (wr_i[i].addr != '0)) begin
                    regs_q[wr_i[i].addr] <= wr_i[i].data;
                end
            end
        end
    end

    // debug read, zero register is hardwired
    assign rd_data_o = (rd_addr_i == '0) ? '0 : regs_q[rd_addr_i];

    // commit must never pair two writes to one register
    a_no_same_dest: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_i[0].en && wr_i[1].en) |-> (wr_i[0].addr != wr_i[1].addr)
    ) else $error("both write ports target register %0d", wr_i[0].addr);

endmodule

// File: hdl/commit_unit.sv
`timescale 1ns/10ps

module commit_unit
    import retire_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [1:0]       head_valid_i,
    input  rob_entry_t [1:0] head_entry_i,
    output logic [1:0]       retire_o,
    output mem_req_t         mem_req_o,
    input  mem_resp_t        mem_resp_i,
    output arf_wr_t [1:0]    arf_wr_o,
    output logic             flush_o,
    output logic             idle_o
);

    commit_state_e state_q;
    commit_state_e state_d;

    // fetch stage
    logic             slot1_block;
    logic [1:0]       f_valid;
    logic [1:0]       f_fire;

    // skid buffer
    logic             skid_ready_q; // high while the skid is empty
    logic [1:0]       skid_valid_q;
    rob_entry_t [1:0] skid_entry_q;

    // handle stage
    logic             h_ready;
    logic [1:0]       h_in_valid;
    rob_entry_t [1:0] h_in_entry;
    logic [1:0]       h_valid_q;
    rob_entry_t [1:0] h_entry_q;

    logic             special_start;
    logic             ustore_done;
    logic             flush_d;
    mem_req_t         mem_req_d;
    arf_wr_t [1:0]    arf_wr_d;

    // slot 1 only for alu pairs writing different registers
    assign slot1_block = (head_entry_i[1].op != op_alu)
                      || (head_entry_i[0].op != op_alu)
                      || (head_entry_i[1].wreg == head_entry_i[0].wreg);
    assign f_valid  = head_valid_i & {~slot1_block, 1'b1};
    assign f_fire   = f_valid & {2{skid_ready_q & ~flush_o}};
    assign retire_o = f_fire;

    assign h_in_valid = skid_ready_q ? f_fire : skid_valid_q;
    assign h_in_entry = skid_ready_q ? head_entry_i : skid_entry_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            skid_ready_q <= 1'b1;
            skid_valid_q <= '0;
        end else if (flush_o) begin
            skid_ready_q <= 1'b1;
            skid_valid_q <= '0;
        end else if (skid_ready_q) begin
            if (!h_ready && (|f_fire)) begin
                skid_ready_q <= 1'b0; // park the pair, stop retiring
                skid_valid_q <= f_fire;
            end
        end else if (h_ready) begin
            skid_ready_q <= 1'b1;
            skid_valid_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (skid_ready_q) begin
            skid_entry_q <= head_entry_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_valid_q <= '0;
        end else if (flush_o) begin
            h_valid_q <= '0;
        end else if (h_ready) begin
            h_valid_q <= h_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (h_ready) begin
            h_entry_q <= h_in_entry;
        end
    end

    // the ustore leaves the handle stage once its ack arrives
    assign h_ready = ((state_q == s_normal) && !special_start) || ustore_done;

    // commit fsm, next state and commit outputs
    always_comb begin
        state_d       = state_q;
        flush_d       = 1'b0;
        mem_req_d     = '0;
        arf_wr_d      = '0;
        special_start = 1'b0;
        ustore_done   = 1'b0;
        case (state_q)
            s_normal: begin
                if (h_valid_q[0] && (h_entry_q[0].op != op_alu)) begin
                    special_start = 1'b1;
                    case (h_entry_q[0].op)
                        op_uload: begin
                            mem_req_d.valid = 1'b1;
                            mem_req_d.addr  = h_entry_q[0].addr;
                            state_d         = s_wait_uload;
                        end
                        op_ustore: begin
                            mem_req_d.valid = 1'b1;
                            mem_req_d.write = 1'b1;
                            mem_req_d.addr  = h_entry_q[0].addr;
                            mem_req_d.wdata = h_entry_q[0].wdata;
                            state_d         = s_wait_ustore;
                        end
                        default: begin // serialize
                            flush_d = 1'b1;
                            state_d = s_wait_flush;
                        end
                    endcase
                end else begin
                    for (int i = 0; i < 2; i++) begin
                        arf_wr_d[i].en   = h_valid_q[i] && (h_entry_q[i].wreg != '0);
                        arf_wr_d[i].addr = h_entry_q[i].wreg;
                        arf_wr_d[i].data = h_entry_q[i].wdata;
                    end
                end
            end
            s_wait_uload: begin
                if (mem_resp_i.valid) begin
                    arf_wr_d[0].en   = (h_entry_q[0].wreg != '0);
                    arf_wr_d[0].addr = h_entry_q[0].wreg;
                    arf_wr_d[0].data = mem_resp_i.rdata;
                    flush_d          = 1'b1; // younger entries saw stale state
                    state_d          = s_wait_flush;
                end
            end
            s_wait_ustore: begin
                if (mem_resp_i.valid) begin
                    ustore_done = 1'b1;
                    state_d     = s_normal;
                end
            end
            s_wait_flush: begin
                if (flush_o) begin
                    state_d = s_normal;
                end
            end
            default: state_d = s_normal;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= s_normal;
            flush_o   <= 1'b0;
            mem_req_o <= '0;
            arf_wr_o  <= '0;
        end else begin
            state_q   <= state_d;
            flush_o   <= flush_d;
            mem_req_o <= mem_req_d;
            arf_wr_o  <= arf_wr_d;
        end
    end

    // nothing in flight inside the commit path
    assign idle_o = (state_q == s_normal) && skid_ready_q && (h_valid_q == 2'b00)
                 && !arf_wr_o[0].en && !arf_wr_o[1].en && !flush_o && !mem_req_o.valid;

    a_req_slot0_alone: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req_o.valid |-> $past(state_q == s_normal && h_valid_q[0] && !h_valid_q[1])
    ) else $error("memory request not from a lone slot 0");

    // a done strobe with no access outstanding would be lost
    a_resp_while_waiting: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_resp_i.valid |-> (state_q == s_wait_uload || state_q == s_wait_ustore)
    ) else $error("memory response while not waiting");

endmodule

// File: hdl/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer
    import retire_pkg::*;
#(
    parameter int ROB_DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             alloc_i,
    input  rob_entry_t       alloc_entry_i,
    output logic             full_o,
    output logic             empty_o,
    output logic [1:0]       head_valid_o,
    output rob_entry_t [1:0] head_entry_o,
    input  logic [1:0]       retire_i,
    input  logic             flush_i
);

    localparam int IDX_W = $clog2(ROB_DEPTH);
    localparam int PTR_W = IDX_W + 1;

    rob_entry_t entries_q [ROB_DEPTH];

    // pointers carry a wrap bit above the index
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W-1:0] count;
    logic [IDX_W-1:0] head_idx0;
    logic [IDX_W-1:0] head_idx1;
    logic [IDX_W-1:0] tail_idx;
    logic [1:0]       pop_cnt;
    logic             do_alloc;

    assign count     = tail_q - head_q;
    assign head_idx0 = head_q[IDX_W-1:0];
    assign head_idx1 = head_idx0 + 1'b1; // wraps with the index width
    assign tail_idx  = tail_q[IDX_W-1:0];

    assign full_o  = (count == PTR_W'(ROB_DEPTH));
    assign empty_o = (count == '0);

    // slot 1 only shows up together with slot 0
    assign head_valid_o[0] = !empty_o;
    assign head_valid_o[1] = (count >= PTR_W'(2));
    assign head_entry_o[0] = entries_q[head_idx0];
    assign head_entry_o[1] = entries_q[head_idx1];

    assign pop_cnt  = {1'b0, retire_i[0]} + {1'b0, retire_i[1]};
    assign do_alloc = alloc_i && !full_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
        end else if (flush_i) begin
            // younger entries are all discarded
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_q + PTR_W'(pop_cnt);
            if (do_alloc) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    // storage itself
    always_ff @(posedge clk) begin
        if (do_alloc) begin
            entries_q[tail_idx] <= alloc_entry_i;
        end
    end

    a_retire_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        !flush_i |-> (PTR_W'(pop_cnt) <= count)
    ) else $error("retire count exceeds occupancy");

    a_retire_in_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_i[1] |-> retire_i[0]
    ) else $error("slot 1 retired without slot 0");

    // dispatch side has to honour the full level
    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        (alloc_i && !flush_i) |-> !full_o
    ) else $error("dispatch while buffer full");

endmodule

// File: hdl/retire_pkg.sv
package retire_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  arch_rid_t;

    // what commit needs to know about an instruction
    typedef enum logic [1:0] {
        op_alu       = 2'd0, // plain result, may go to slot 1
        op_uload     = 2'd1, // uncached load, flushes afterwards
        op_ustore    = 2'd2, // uncached store, no flush
        op_serialize = 2'd3  // flush right away
    } commit_op_e;

    // commit fsm states, shared with top-level idle logic
    typedef enum logic [1:0] {
        s_normal      = 2'd0,
        s_wait_uload  = 2'd1,
        s_wait_ustore = 2'd2,
        s_wait_flush  = 2'd3
    } commit_state_e;

    // reorder buffer entry, already complete on dispatch
    typedef struct packed {
        commit_op_e op;
        arch_rid_t  wreg;  // destination
        word_t      wdata; // alu result or store data
        word_t      addr;  // uncached address
    } rob_entry_t;

    // uncached memory request, valid is a one-cycle strobe
    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    // done strobe plus read data
    typedef struct packed {
        logic  valid;
        word_t rdata;
    } mem_resp_t;

    // one register file write port
    typedef struct packed {
        logic      en;
        arch_rid_t addr;
        word_t     data;
    } arf_wr_t;

endpackage
